// ==== src/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = 4;

  // device map
  // serial port takes stores only, one character per store
  localparam logic [ADDR_W-1:0] SERIAL_ADDR = 32'ha000_03f8;

  // clint mtime, readable as two 32-bit words
  localparam logic [ADDR_W-1:0] CLINT_MTIME_LO = 32'ha000_0048;
  localparam logic [ADDR_W-1:0] CLINT_MTIME_HI = 32'ha000_004c;

  // owner of the single outstanding read
  // OWN_NONE means the read path is idle and can take a new request
  // the lsu owners also encode the target the read went to
  typedef enum logic [1:0] {
    OWN_NONE      = 2'd0,
    OWN_IFU       = 2'd1,
    OWN_LSU_MEM   = 2'd2,
    OWN_LSU_CLINT = 2'd3
  } read_owner_t;

endpackage : bus_pkg

`default_nettype wire

// ==== src/dev_bus_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// request and response path between the arbiter and one device
interface dev_bus_if;
  import bus_pkg::*;

  // host side
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              rd_req;
  logic              wr_req;

  // device side
  logic [DATA_W-1:0] rdata;
  logic              rvalid;
  logic              wready;

  modport host (
    output addr, wdata, wstrb, rd_req, wr_req,
    input  rdata, rvalid, wready
  );

  modport dev (
    input  addr, wdata, wstrb, rd_req, wr_req,
    output rdata, rvalid, wready
  );

endinterface : dev_bus_if

`default_nettype wire

// ==== src/bus_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
  input  logic                         clk,
  input  logic                         rst,

  // ifu fetch
  input  logic [bus_pkg::ADDR_W-1:0]   ifu_araddr_i,
  input  logic                         ifu_arvalid_i,
  output logic [bus_pkg::DATA_W-1:0]   ifu_rdata_o,
  output logic                         ifu_rvalid_o,

  // lsu load
  input  logic [bus_pkg::ADDR_W-1:0]   lsu_araddr_i,
  input  logic                         lsu_arvalid_i,
  output logic [bus_pkg::DATA_W-1:0]   lsu_rdata_o,
  output logic                         lsu_rvalid_o,

  // lsu store
  input  logic [bus_pkg::ADDR_W-1:0]   lsu_awaddr_i,
  input  logic [bus_pkg::DATA_W-1:0]   lsu_wdata_i,
  input  logic [bus_pkg::STRB_W-1:0]   lsu_wstrb_i,
  input  logic                         lsu_wvalid_i,
  output logic                         lsu_wready_o,

  // external memory
  output logic [bus_pkg::ADDR_W-1:0]   mem_araddr_o,
  output logic                         mem_arvalid_o,
  input  logic [bus_pkg::DATA_W-1:0]   mem_rdata_i,
  input  logic                         mem_rvalid_i,
  output logic [bus_pkg::ADDR_W-1:0]   mem_awaddr_o,
  output logic [bus_pkg::DATA_W-1:0]   mem_wdata_o,
  output logic [bus_pkg::STRB_W-1:0]   mem_wstrb_o,
  output logic                         mem_wvalid_o,
  input  logic                         mem_wready_i,

  // local devices
  dev_bus_if.host                      serial_bus,
  dev_bus_if.host                      clint_bus
);
  import bus_pkg::*;

  read_owner_t owner;
  logic        lsu_clint_hit;
  logic        serial_sel;
  logic        rd_done;
  logic        owner_mem;

  // lsu load decode, only mtime words go to the timer
  assign lsu_clint_hit = (lsu_araddr_i == CLINT_MTIME_LO) ||
                         (lsu_araddr_i == CLINT_MTIME_HI);

  assign owner_mem = (owner == OWN_IFU) || (owner == OWN_LSU_MEM);

  // end of the outstanding read, from whichever target holds it
  assign rd_done = (owner_mem && mem_rvalid_i) ||
                   ((owner == OWN_LSU_CLINT) && clint_bus.rvalid);

  // owner tracking
  // lsu wins a tie, ifu keeps waiting with its request held
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      owner <= OWN_NONE;
    end
    else if (owner == OWN_NONE)
    begin
      if (lsu_arvalid_i)
      begin
        owner <= lsu_clint_hit ? OWN_LSU_CLINT : OWN_LSU_MEM;
      end
      else if (ifu_arvalid_i)
      begin
        owner <= OWN_IFU;
      end
    end
    else if (rd_done)
    begin
      owner <= OWN_NONE;
    end
  end

  // memory read request, held for the whole outstanding read
  assign mem_arvalid_o = owner_mem;
  assign mem_araddr_o  = (owner == OWN_IFU) ? ifu_araddr_i : lsu_araddr_i;

  // timer read request
  assign clint_bus.rd_req = (owner == OWN_LSU_CLINT);
  assign clint_bus.addr   = lsu_araddr_i;
  // timer is read only
  assign clint_bus.wr_req = 1'b0;
  assign clint_bus.wdata  = '0;
  assign clint_bus.wstrb  = '0;

  // responses go back to the owner only
  assign ifu_rvalid_o = (owner == OWN_IFU) && mem_rvalid_i;
  assign ifu_rdata_o  = (owner == OWN_IFU) ? mem_rdata_i : '0;

  assign lsu_rvalid_o = ((owner == OWN_LSU_MEM) && mem_rvalid_i) ||
                        ((owner == OWN_LSU_CLINT) && clint_bus.rvalid);

  always_comb
  begin
    unique case (owner)
      OWN_LSU_MEM:   lsu_rdata_o = mem_rdata_i;
      OWN_LSU_CLINT: lsu_rdata_o = clint_bus.rdata;
      default:       lsu_rdata_o = '0;
    endcase
  end

  // store steering, separate from the read path
  assign serial_sel = (lsu_awaddr_i == SERIAL_ADDR);

  assign serial_bus.addr   = lsu_awaddr_i;
  assign serial_bus.wdata  = lsu_wdata_i;
  assign serial_bus.wstrb  = lsu_wstrb_i;
  assign serial_bus.wr_req = lsu_wvalid_i && serial_sel;
  assign serial_bus.rd_req = 1'b0;

  assign mem_awaddr_o = lsu_awaddr_i;
  assign mem_wdata_o  = lsu_wdata_i;
  assign mem_wstrb_o  = lsu_wstrb_i;
  assign mem_wvalid_o = lsu_wvalid_i && !serial_sel;

  assign lsu_wready_o = serial_sel ? serial_bus.wready : mem_wready_i;

endmodule : bus_arbiter

`default_nettype wire

// ==== src/serial_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module serial_port (
  input  logic       clk,
  input  logic       rst,
  dev_bus_if.dev     bus,
  output logic [7:0] char_o,
  output logic       char_valid_o
);

  logic busy;
  logic accept;
  logic wready_q;

  // one character per store, a held wr_req must drop first
  assign accept = bus.wr_req && !busy;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy         <= 1'b0;
      char_valid_o <= 1'b0;
      wready_q     <= 1'b0;
    end
    else
    begin
      busy         <= bus.wr_req;
      char_valid_o <= accept;
      wready_q     <= accept;
    end
  end

  // character byte
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      char_o <= bus.wdata[7:0];
    end
  end

  assign bus.wready = wready_q;

  // write only device
  assign bus.rdata  = '0;
  assign bus.rvalid = 1'b0;

endmodule : serial_port

`default_nettype wire

// ==== src/clint_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module clint_timer (
  input  logic   clk,
  input  logic   rst,
  dev_bus_if.dev bus
);
  import bus_pkg::*;

  logic [63:0]       mtime;
  logic [DATA_W-1:0] rdata_q;
  logic              rvalid_q;

  // free running, counts from 0 after reset
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime <= '0;
    end
    else
    begin
      mtime <= mtime + 64'd1;
    end
  end

  // single pulse per request even while rd_req stays high
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rvalid_q <= 1'b0;
    end
    else
    begin
      rvalid_q <= bus.rd_req && !rvalid_q;
    end
  end

  // word select on the read address
  always_ff @(posedge clk)
  begin
    if (bus.rd_req && !rvalid_q)
    begin
      rdata_q <= (bus.addr == CLINT_MTIME_HI) ? mtime[63:32] : mtime[31:0];
    end
  end

  assign bus.rdata  = rdata_q;
  assign bus.rvalid = rvalid_q;
  // no writable registers here
  assign bus.wready = 1'b0;

endmodule : clint_timer

`default_nettype wire

// ==== src/bus_subsystem_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_subsystem_top (
  input  logic                         clk,
  input  logic                         rst,

  // ifu fetch
  input  logic [bus_pkg::ADDR_W-1:0]   ifu_araddr_i,
  input  logic                         ifu_arvalid_i,
  output logic [bus_pkg::DATA_W-1:0]   ifu_rdata_o,
  output logic                         ifu_rvalid_o,

  // lsu load
  input  logic [bus_pkg::ADDR_W-1:0]   lsu_araddr_i,
  input  logic                         lsu_arvalid_i,
  output logic [bus_pkg::DATA_W-1:0]   lsu_rdata_o,
  output logic                         lsu_rvalid_o,

  // lsu store
  input  logic [bus_pkg::ADDR_W-1:0]   lsu_awaddr_i,
  input  logic [bus_pkg::DATA_W-1:0]   lsu_wdata_i,
  input  logic [bus_pkg::STRB_W-1:0]   lsu_wstrb_i,
  input  logic                         lsu_wvalid_i,
  output logic                         lsu_wready_o,

  // external memory
  output logic [bus_pkg::ADDR_W-1:0]   mem_araddr_o,
  output logic                         mem_arvalid_o,
  input  logic [bus_pkg::DATA_W-1:0]   mem_rdata_i,
  input  logic                         mem_rvalid_i,
  output logic [bus_pkg::ADDR_W-1:0]   mem_awaddr_o,
  output logic [bus_pkg::DATA_W-1:0]   mem_wdata_o,
  output logic [bus_pkg::STRB_W-1:0]   mem_wstrb_o,
  output logic                         mem_wvalid_o,
  input  logic                         mem_wready_i,

  // serial output
  output logic [7:0]                   serial_char_o,
  output logic                         serial_char_valid_o
);

  dev_bus_if serial_bus ();
  dev_bus_if clint_bus ();

  bus_arbiter u_arbiter (
    .clk           (clk),
    .rst           (rst),
    .ifu_araddr_i  (ifu_araddr_i),
    .ifu_arvalid_i (ifu_arvalid_i),
    .ifu_rdata_o   (ifu_rdata_o),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_rdata_o   (lsu_rdata_o),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_wstrb_i   (lsu_wstrb_i),
    .lsu_wvalid_i  (lsu_wvalid_i),
    .lsu_wready_o  (lsu_wready_o),
    .mem_araddr_o  (mem_araddr_o),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_rdata_i   (mem_rdata_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_awaddr_o  (mem_awaddr_o),
    .mem_wdata_o   (mem_wdata_o),
    .mem_wstrb_o   (mem_wstrb_o),
    .mem_wvalid_o  (mem_wvalid_o),
    .mem_wready_i  (mem_wready_i),
    .serial_bus    (serial_bus.host),
    .clint_bus     (clint_bus.host)
  );

  serial_port u_serial (
    .clk          (clk),
    .rst          (rst),
    .bus          (serial_bus.dev),
    .char_o       (serial_char_o),
    .char_valid_o (serial_char_valid_o)
  );

  clint_timer u_clint (
    .clk (clk),
    .rst (rst),
    .bus (clint_bus.dev)
  );

endmodule : bus_subsystem_top

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 4
) (
  output logic clk_o
);

  // free running, starts low
  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule : tb_clock

`default_nettype wire

// ==== tb/bus_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_checker (
  input wire logic                       clk_i,
  input wire logic                       rst_i,
  input wire logic                       ifu_arvalid_i,
  input wire logic                       lsu_arvalid_i,
  input wire logic [bus_pkg::ADDR_W-1:0] lsu_araddr_i,
  input wire logic                       ifu_rvalid_i,
  input wire logic                       lsu_rvalid_i,
  input wire logic                       lsu_wready_i,
  input wire logic                       mem_arvalid_i,
  input wire logic                       mem_wvalid_i,
  input wire logic                       char_valid_i
);
  import bus_pkg::*;

  int   fail_count = 0;
  logic lsu_timer_addr;

  // lsu load aimed at one of the mtime words
  assign lsu_timer_addr = (lsu_araddr_i == CLINT_MTIME_LO) ||
                          (lsu_araddr_i == CLINT_MTIME_HI);

  // responses and readies are single cycle strobes
  ifu_pulse_a: assert property (@(posedge clk_i) disable iff (rst_i)
    ifu_rvalid_i |=> !ifu_rvalid_i)
    else
    begin
      fail_count++;
      $error("ifu_rvalid_o stayed high for more than one cycle");
    end

  lsu_pulse_a: assert property (@(posedge clk_i) disable iff (rst_i)
    lsu_rvalid_i |=> !lsu_rvalid_i)
    else
    begin
      fail_count++;
      $error("lsu_rvalid_o stayed high for more than one cycle");
    end

  wready_pulse_a: assert property (@(posedge clk_i) disable iff (rst_i)
    lsu_wready_i |=> !lsu_wready_i)
    else
    begin
      fail_count++;
      $error("lsu_wready_o stayed high for more than one cycle");
    end

  char_pulse_a: assert property (@(posedge clk_i) disable iff (rst_i)
    char_valid_i |=> !char_valid_i)
    else
    begin
      fail_count++;
      $error("serial_char_valid_o stayed high for more than one cycle");
    end

  // a response goes to one requester only
  rvalid_excl_a: assert property (@(posedge clk_i) disable iff (rst_i)
    !(ifu_rvalid_i && lsu_rvalid_i))
    else
    begin
      fail_count++;
      $error("ifu and lsu responses were returned in the same cycle");
    end

  // timer reads never reach memory
  // with no ifu request held, a held lsu timer load owns the read path
  timer_no_mem_a: assert property (@(posedge clk_i) disable iff (rst_i)
    (lsu_arvalid_i && lsu_timer_addr && !ifu_arvalid_i) |-> !mem_arvalid_i)
    else
    begin
      fail_count++;
      $error("memory read issued while a timer read was outstanding");
    end

  reset_idle_a: assert property (@(posedge clk_i)
    rst_i |=> !(ifu_rvalid_i || lsu_rvalid_i || lsu_wready_i ||
                mem_arvalid_i || mem_wvalid_i || char_valid_i))
    else
    begin
      fail_count++;
      $error("an output was active right after reset");
    end

endmodule : bus_checker

`default_nettype wire

// ==== tb/bus_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_tb;
  import bus_pkg::*;

  localparam int SEED_INIT  = 10;
  localparam int RD_TIMEOUT = 20;
  localparam int WR_TIMEOUT = 20;
  // memory read data is the address with this pattern folded in
  localparam logic [DATA_W-1:0] MEM_XOR = 32'ha5a5_0000;

  logic              clk;
  logic              rst;
  logic [ADDR_W-1:0] ifu_araddr_i;
  logic              ifu_arvalid_i;
  logic [DATA_W-1:0] ifu_rdata_o;
  logic              ifu_rvalid_o;
  logic [ADDR_W-1:0] lsu_araddr_i;
  logic              lsu_arvalid_i;
  logic [DATA_W-1:0] lsu_rdata_o;
  logic              lsu_rvalid_o;
  logic [ADDR_W-1:0] lsu_awaddr_i;
  logic [DATA_W-1:0] lsu_wdata_i;
  logic [STRB_W-1:0] lsu_wstrb_i;
  logic              lsu_wvalid_i;
  logic              lsu_wready_o;
  logic [ADDR_W-1:0] mem_araddr_o;
  logic              mem_arvalid_o;
  logic [DATA_W-1:0] mem_rdata_i;
  logic              mem_rvalid_i;
  logic [ADDR_W-1:0] mem_awaddr_o;
  logic [DATA_W-1:0] mem_wdata_o;
  logic [STRB_W-1:0] mem_wstrb_o;
  logic              mem_wvalid_o;
  logic              mem_wready_i;
  logic [7:0]        serial_char_o;
  logic              serial_char_valid_o;

  integer seed = SEED_INIT;
  string  cur_test;
  int     errors = 0;
  int     errors_at_start = 0;
  int     asserts_at_start = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     chk_fails = 0;
  int     cycle_cnt = 0;

  // output activity seen at falling edges
  int         ifu_pulses = 0;
  int         char_pulses = 0;
  int         mem_rd_cycles = 0;
  int         mem_wr_cycles = 0;
  logic [7:0] last_char = '0;

  // memory model state
  logic [ADDR_W-1:0] rd_addr;
  logic [ADDR_W-1:0] rec_waddr;
  logic [DATA_W-1:0] rec_wdata;
  logic [STRB_W-1:0] rec_wstrb;
  int                mem_delay;

  // test sequence scratch
  logic [DATA_W-1:0] rdata_a;
  logic [DATA_W-1:0] rdata_b;
  logic              rdy_with_mem;
  int                lat;
  int                t_a;
  int                t_b;
  int                ifu_at;
  int                lsu_at;
  int                waited;
  int                snap_a;
  int                snap_b;

  tb_clock #(.PERIOD_NS(4)) clk_gen (.clk_o(clk));

  bus_subsystem_top dut0 (.*);

  bind bus_subsystem_top bus_checker chk0 (
    .clk_i          (clk),
    .rst_i          (rst),
    .ifu_arvalid_i  (ifu_arvalid_i),
    .lsu_arvalid_i  (lsu_arvalid_i),
    .lsu_araddr_i   (lsu_araddr_i),
    .ifu_rvalid_i   (ifu_rvalid_o),
    .lsu_rvalid_i   (lsu_rvalid_o),
    .lsu_wready_i   (lsu_wready_o),
    .mem_arvalid_i  (mem_arvalid_o),
    .mem_wvalid_i   (mem_wvalid_o),
    .char_valid_i   (serial_char_valid_o)
  );

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
  end

  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (ifu_rvalid_o)
        ifu_pulses <= ifu_pulses + 1;
      if (mem_arvalid_o)
        mem_rd_cycles <= mem_rd_cycles + 1;
      if (mem_wvalid_o)
        mem_wr_cycles <= mem_wr_cycles + 1;
      if (serial_char_valid_o)
      begin
        char_pulses <= char_pulses + 1;
        last_char   <= serial_char_o;
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++)
      next_cycle();
  endtask

  // memory model takes one read or one write at a time with random latency
  initial
  begin
    mem_rdata_i  = '0;
    mem_rvalid_i = 1'b0;
    mem_wready_i = 1'b0;
    forever
    begin
      @(negedge clk);
      if (!rst && mem_arvalid_o)
      begin
        rd_addr   = mem_araddr_o;
        mem_delay = 1 + ($unsigned($random(seed)) % 4);
        repeat (mem_delay) @(posedge clk);
        #1;
        mem_rdata_i  = rd_addr ^ MEM_XOR;
        mem_rvalid_i = 1'b1;
        next_cycle();
        mem_rvalid_i = 1'b0;
      end
      else if (!rst && mem_wvalid_o)
      begin
        rec_waddr = mem_awaddr_o;
        rec_wdata = mem_wdata_o;
        rec_wstrb = mem_wstrb_o;
        mem_delay = 1 + ($unsigned($random(seed)) % 3);
        repeat (mem_delay) @(posedge clk);
        #1;
        mem_wready_i = 1'b1;
        next_cycle();
        mem_wready_i = 1'b0;
      end
    end
  end

  task automatic start_test(input string name);
    cur_test         = name;
    errors_at_start  = errors;
    asserts_at_start = dut0.chk0.fail_count;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == errors_at_start && dut0.chk0.fail_count == asserts_at_start)
      $display("test %s: ok", cur_test);
    else
    begin
      tests_failed++;
      $display("test %s: FAILED", cur_test);
    end
  endtask

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("ERROR %s %s: expected %h actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond)
    else
    begin
      $display("%s: %s", cur_test, msg);
      errors++;
    end
  endtask

  // entered and left 1 ns after a rising edge
  task automatic do_read(input logic from_lsu, input logic [ADDR_W-1:0] addr,
                         output logic [DATA_W-1:0] data, output int rd_lat,
                         output int start);
    logic got;
    got    = 1'b0;
    rd_lat = 0;
    data   = '0;
    start  = cycle_cnt;
    if (from_lsu)
    begin
      lsu_araddr_i  = addr;
      lsu_arvalid_i = 1'b1;
    end
    else
    begin
      ifu_araddr_i  = addr;
      ifu_arvalid_i = 1'b1;
    end
    while (!got && rd_lat < RD_TIMEOUT)
    begin
      @(negedge clk);
      if (from_lsu ? lsu_rvalid_o : ifu_rvalid_o)
      begin
        got  = 1'b1;
        data = from_lsu ? lsu_rdata_o : ifu_rdata_o;
      end
      else
        rd_lat++;
    end
    if (!got)
    begin
      $display("%s: read of %h got no response within %0d cycles", cur_test, addr, RD_TIMEOUT);
      errors++;
    end
    next_cycle();
    lsu_arvalid_i = 1'b0;
    ifu_arvalid_i = 1'b0;
  endtask

  task automatic do_store(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                          input logic [STRB_W-1:0] strb, output int wr_lat,
                          output logic mem_rdy);
    logic got;
    got          = 1'b0;
    wr_lat       = 0;
    mem_rdy      = 1'b0;
    lsu_awaddr_i = addr;
    lsu_wdata_i  = data;
    lsu_wstrb_i  = strb;
    lsu_wvalid_i = 1'b1;
    while (!got && wr_lat < WR_TIMEOUT)
    begin
      @(negedge clk);
      if (lsu_wready_o)
      begin
        got     = 1'b1;
        mem_rdy = mem_wready_i;
      end
      else
        wr_lat++;
    end
    if (!got)
    begin
      $display("%s: store to %h was not accepted within %0d cycles", cur_test, addr, WR_TIMEOUT);
      errors++;
    end
    next_cycle();
    lsu_wvalid_i = 1'b0;
  endtask

  initial
  begin
    rst           = 1'b1;
    ifu_araddr_i  = '0;
    ifu_arvalid_i = 1'b0;
    lsu_araddr_i  = '0;
    lsu_arvalid_i = 1'b0;
    lsu_awaddr_i  = '0;
    lsu_wdata_i   = '0;
    lsu_wstrb_i   = '0;
    lsu_wvalid_i  = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    start_test("reset_state");
    @(negedge clk);
    check_eq("strobes", 32'd0, {26'd0, ifu_rvalid_o, lsu_rvalid_o, lsu_wready_o,
                                mem_arvalid_o, mem_wvalid_o, serial_char_valid_o});
    next_cycle();
    finish_test();

    start_test("ifu_read");
    snap_a = ifu_pulses;
    do_read(1'b0, 32'h0000_1000, rdata_a, lat, t_a);
    idle(4);
    check_eq("data", 32'h0000_1000 ^ MEM_XOR, rdata_a);
    check_eq("rvalid pulses", snap_a + 1, ifu_pulses);
    finish_test();

    // both requesters ask at once and the lsu has priority
    start_test("read_priority");
    ifu_araddr_i  = 32'h0000_2000;
    ifu_arvalid_i = 1'b1;
    lsu_araddr_i  = 32'h0000_3004;
    lsu_arvalid_i = 1'b1;
    ifu_at        = -1;
    lsu_at        = -1;
    waited        = 0;
    while ((ifu_at < 0 || lsu_at < 0) && waited < 2 * RD_TIMEOUT)
    begin
      @(negedge clk);
      if (lsu_rvalid_o)
      begin
        lsu_at  = waited;
        rdata_a = lsu_rdata_o;
      end
      if (ifu_rvalid_o)
      begin
        ifu_at  = waited;
        rdata_b = ifu_rdata_o;
      end
      next_cycle();
      if (lsu_at >= 0)
        lsu_arvalid_i = 1'b0;
      if (ifu_at >= 0)
        ifu_arvalid_i = 1'b0;
      waited++;
    end
    if (ifu_at < 0 || lsu_at < 0)
    begin
      $display("%s: both reads did not complete within %0d cycles", cur_test, 2 * RD_TIMEOUT);
      errors++;
    end
    else
    begin
      check_true(lsu_at < ifu_at, "lsu response did not arrive before the ifu response");
      check_eq("lsu data", 32'h0000_3004 ^ MEM_XOR, rdata_a);
      check_eq("ifu data", 32'h0000_2000 ^ MEM_XOR, rdata_b);
    end
    ifu_arvalid_i = 1'b0;
    lsu_arvalid_i = 1'b0;
    idle(2);
    finish_test();

    start_test("mem_store");
    snap_a = char_pulses;
    do_store(32'h0000_4008, 32'hdead_beef, 4'b0110, lat, rdy_with_mem);
    idle(2);
    check_eq("awaddr", 32'h0000_4008, rec_waddr);
    check_eq("wdata", 32'hdead_beef, rec_wdata);
    check_eq("wstrb", 32'h6, {28'd0, rec_wstrb});
    check_true(rdy_with_mem, "lsu_wready_o pulsed without mem_wready_i");
    check_eq("char pulses", snap_a, char_pulses);
    finish_test();

    start_test("serial_store");
    snap_a = char_pulses;
    snap_b = mem_wr_cycles;
    do_store(SERIAL_ADDR, 32'h1234_5641, 4'b0001, lat, rdy_with_mem);
    idle(3);
    check_eq("wready latency", 1, lat);
    check_eq("char pulses", snap_a + 1, char_pulses);
    check_eq("char", 32'h41, {24'd0, last_char});
    check_eq("mem write cycles", snap_b, mem_wr_cycles);
    finish_test();

    // mtime counts every cycle, so the gap between reads sets the step
    start_test("timer_read");
    snap_a = mem_rd_cycles;
    do_read(1'b1, CLINT_MTIME_LO, rdata_a, lat, t_a);
    check_eq("lo latency", 2, lat);
    idle(5);
    do_read(1'b1, CLINT_MTIME_LO, rdata_b, lat, t_b);
    check_eq("lo latency", 2, lat);
    check_eq("mtime step", t_b - t_a, rdata_b - rdata_a);
    do_read(1'b1, CLINT_MTIME_HI, rdata_a, lat, t_a);
    check_eq("hi word", 32'd0, rdata_a);
    idle(2);
    check_eq("mem read cycles", snap_a, mem_rd_cycles);
    finish_test();

    chk_fails = dut0.chk0.fail_count;
    $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, chk_fails);
    if (errors == 0 && tests_failed == 0 && chk_fails == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule : bus_tb

`default_nettype wire

// ==== verilog.f ====
src/bus_pkg.sv
src/dev_bus_if.sv
src/bus_arbiter.sv
src/serial_port.sv
src/clint_timer.sv
src/bus_subsystem_top.sv
tb/tb_clock.sv
tb/bus_checker.sv
tb/bus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, then look for the pass line in the simulation output
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module bus_tb -f verilog.f &&
  ./obj_dir/Vbus_tb | awk '{ print } /^sim passed$/ { ok = 1 } END { exit !ok }' &&
  echo "run_sim: PASS" ||
  { echo "run_sim: FAIL"; exit 1; }
